// ==== hw/mpls_egress_pkg.sv ====
// MPLS egress shared definitions

package mpls_egress_pkg;

    //////////////////////////////
    // Egress bus geometry
    //////////////////////////////

    // Bytes carried by one egress word
    localparam int egr_data_bytes = 8;

    // Bits carried by one egress word
    localparam int egr_data_bits = egr_data_bytes * 8;

    // Port tag width on the egress bus
    localparam int egr_port_idx_bits = 3;

    // Highest number of physical ports the tag can address
    localparam int egr_max_ports = 2 ** egr_port_idx_bits;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Destination port number that travels with every word
    typedef logic [egr_port_idx_bits-1:0] egr_port_idx_t;

    // Byte enables of one word, contiguous from bit 0
    typedef logic [egr_data_bytes-1:0] egr_keep_t;

    // One egress word seen as byte lanes or as 32-bit lanes
    // Element 0 of either view sits in the lowest bits and leaves first
    typedef union packed {
        logic [egr_data_bytes-1:0][7:0]         as_bytes;
        logic [egr_data_bits/32-1:0][31:0]      as_words;
    } egr_word_u;

endpackage

// ==== hw/egress_port_fifo.sv ====
// Egress port word buffer

module egress_port_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                        clk_ifc,
    input  logic                        rst_n,

    // Write side from the port decoder
    input  logic                        wr_en,
    input  mpls_egress_pkg::egr_word_u  wr_word,
    input  mpls_egress_pkg::egr_keep_t  wr_keep,
    input  logic                        wr_last,

    // Read side toward the serializer
    input  logic                        rd_pop,
    output logic                        rd_valid,
    output mpls_egress_pkg::egr_word_u  rd_word,
    output mpls_egress_pkg::egr_keep_t  rd_keep,
    output logic                        rd_last,

    // Sticky until reset
    output logic                        overflow
);

    localparam int ptr_bits = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_bits = $clog2(fifo_depth + 1);

    mpls_egress_pkg::egr_word_u mem_word [fifo_depth];
    mpls_egress_pkg::egr_keep_t mem_keep [fifo_depth];
    logic                       mem_last [fifo_depth];

    logic [ptr_bits-1:0]        wr_ptr;
    logic [ptr_bits-1:0]        rd_ptr;
    logic [cnt_bits-1:0]        count;
    logic                       full;
    logic                       wr_ok;

    // Circular increment for a depth that need not be a power of two
    function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] ptr);
        if (ptr == ptr_bits'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == cnt_bits'(fifo_depth));
    assign wr_ok = wr_en && !full;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (wr_ok) begin
            mem_word[wr_ptr] <= wr_word;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    assign rd_word = mem_word[rd_ptr];
    assign rd_keep = mem_keep[rd_ptr];
    assign rd_last = mem_last[rd_ptr];

    //////////////////////////////
    // Pointers, count and flags
    //////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_bits'(wr_ok) - cnt_bits'(rd_pop);
            // A fresh word shows one edge after it is stored
            rd_valid <= (count != cnt_bits'(rd_pop));
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // Serializer must only pop a word that is being presented
    a_pop_needs_valid: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        rd_pop |-> rd_valid
    );

endmodule

// ==== hw/egress_width_serializer.sv ====
// Egress width serializer

module egress_width_serializer #(
    parameter int lane_bytes = 1
) (
    input  logic                        clk_ifc,
    input  logic                        rst_n,

    // Buffered words from the port fifo
    input  logic                        rd_valid,
    input  mpls_egress_pkg::egr_word_u  rd_word,
    input  mpls_egress_pkg::egr_keep_t  rd_keep,
    input  logic                        rd_last,
    output logic                        rd_pop,

    // Physical port
    output logic                        out_valid,
    output logic [lane_bytes*8-1:0]     out_data,
    output logic [lane_bytes-1:0]       out_keep,
    output logic                        out_last,
    input  logic                        out_ready
);

    localparam int num_lanes     = mpls_egress_pkg::egr_data_bytes / lane_bytes;
    localparam int lane_idx_bits = $clog2(num_lanes);

    mpls_egress_pkg::egr_word_u cur_word;
    mpls_egress_pkg::egr_keep_t cur_keep;
    mpls_egress_pkg::egr_keep_t rest_keep;
    logic                       cur_last;
    logic [lane_idx_bits-1:0]   lane_idx;
    logic                       final_lane;
    logic                       xfer;
    logic                       load;

    // Only byte lanes and 32-bit lanes have a matching word view
    if (lane_bytes != 1 && lane_bytes != 4) begin : g_bad_lane
        $error("egress_width_serializer supports lane_bytes of 1 or 4 only");
    end

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    assign xfer = out_valid && out_ready;

    // Take a new word only once the previous one has fully drained
    assign load   = rd_valid && !out_valid;
    assign rd_pop = load;

    //////////////////////////////
    // Lane selection
    //////////////////////////////

    if (lane_bytes == 1) begin : g_byte_lanes
        assign out_data = cur_word.as_bytes[lane_idx];
    end else begin : g_word_lanes
        assign out_data = cur_word.as_words[lane_idx];
    end

    assign out_keep = cur_keep[lane_idx*lane_bytes +: lane_bytes];

    // Keep bits above the current lane
    // Keep is contiguous, so nothing left there means this lane ends the word
    assign rest_keep  = cur_keep >> (lane_bytes * (int'(lane_idx) + 1));
    assign final_lane = (rest_keep == '0);
    assign out_last   = cur_last && final_lane;

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            lane_idx  <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            lane_idx  <= '0;
        end else if (xfer) begin
            if (final_lane) begin
                out_valid <= 1'b0;
            end else begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    // Current word
    always_ff @(posedge clk_ifc) begin
        if (load) begin
            cur_word <= rd_word;
            cur_keep <= rd_keep;
            cur_last <= rd_last;
        end
    end

    // Port holds its beat while the sink stalls
    a_hold_on_stall: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
            && $stable(out_keep) && $stable(out_last)
    );

endmodule

// ==== hw/mpls_egress.sv ====
// MPLS egress stage
// Port demultiplexer and per-port slices

module mpls_egress #(
    parameter int num_8b_ports  = 3,
    parameter int num_32b_ports = 3,
    parameter int fifo_depth    = 16
) (
    input  logic                                clk_ifc,
    input  logic                                rst_n,

    // Egress bus without back-pressure
    input  logic                                egr_valid,
    input  mpls_egress_pkg::egr_word_u          egr_data,
    input  mpls_egress_pkg::egr_keep_t          egr_keep,
    input  logic                                egr_last,
    input  mpls_egress_pkg::egr_port_idx_t      egr_port,

    // 8-bit physical ports
    output logic [num_8b_ports-1:0]             p8_valid,
    output logic [num_8b_ports-1:0][7:0]        p8_data,
    output logic [num_8b_ports-1:0]             p8_last,
    input  logic [num_8b_ports-1:0]             p8_ready,

    // 32-bit physical ports
    output logic [num_32b_ports-1:0]            p32_valid,
    output logic [num_32b_ports-1:0][31:0]      p32_data,
    output logic [num_32b_ports-1:0][3:0]       p32_keep,
    output logic [num_32b_ports-1:0]            p32_last,
    input  logic [num_32b_ports-1:0]            p32_ready,

    // Buffer overflow flags
    output logic [num_8b_ports-1:0]             overflow_8b,
    output logic [num_32b_ports-1:0]            overflow_32b
);

    localparam int num_ports      = num_8b_ports + num_32b_ports;
    localparam int p8_lane_bytes  = 1;
    localparam int p32_lane_bytes = 4;

    logic [num_ports-1:0] wr_en;
    logic [num_ports-1:0] overflow_all;

    if (num_ports > mpls_egress_pkg::egr_max_ports) begin : g_bad_port_count
        $error("mpls_egress has more ports than the port tag can address");
    end

    //////////////////////////////
    // Port tag decode
    //////////////////////////////

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            wr_en[p] = egr_valid && (egr_port == mpls_egress_pkg::egr_port_idx_t'(p));
        end
    end

    // A tag outside the built ports would silently lose the packet
    a_port_in_range: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        egr_valid |-> int'(egr_port) < num_ports
    );

    //////////////////////////////
    // Port slices
    //////////////////////////////

    // Lower port numbers are the 8-bit group, the rest are 32-bit
    for (genvar p = 0; p < num_ports; p++) begin : g_port
        mpls_egress_pkg::egr_word_u rd_word;
        mpls_egress_pkg::egr_keep_t rd_keep;
        logic                       rd_valid;
        logic                       rd_last;
        logic                       rd_pop;

        egress_port_fifo #(
            .fifo_depth (fifo_depth)
        ) fifo_i (
            .clk_ifc    (clk_ifc),
            .rst_n      (rst_n),
            .wr_en      (wr_en[p]),
            .wr_word    (egr_data),
            .wr_keep    (egr_keep),
            .wr_last    (egr_last),
            .rd_pop     (rd_pop),
            .rd_valid   (rd_valid),
            .rd_word    (rd_word),
            .rd_keep    (rd_keep),
            .rd_last    (rd_last),
            .overflow   (overflow_all[p])
        );

        if (p < num_8b_ports) begin : g_8b
            // Every byte sent is a kept byte, so keep stays internal
            egress_width_serializer #(
                .lane_bytes (p8_lane_bytes)
            ) ser_i (
                .clk_ifc    (clk_ifc),
                .rst_n      (rst_n),
                .rd_valid   (rd_valid),
                .rd_word    (rd_word),
                .rd_keep    (rd_keep),
                .rd_last    (rd_last),
                .rd_pop     (rd_pop),
                .out_valid  (p8_valid[p]),
                .out_data   (p8_data[p]),
                .out_keep   (),
                .out_last   (p8_last[p]),
                .out_ready  (p8_ready[p])
            );
        end else begin : g_32b
            egress_width_serializer #(
                .lane_bytes (p32_lane_bytes)
            ) ser_i (
                .clk_ifc    (clk_ifc),
                .rst_n      (rst_n),
                .rd_valid   (rd_valid),
                .rd_word    (rd_word),
                .rd_keep    (rd_keep),
                .rd_last    (rd_last),
                .rd_pop     (rd_pop),
                .out_valid  (p32_valid[p-num_8b_ports]),
                .out_data   (p32_data[p-num_8b_ports]),
                .out_keep   (p32_keep[p-num_8b_ports]),
                .out_last   (p32_last[p-num_8b_ports]),
                .out_ready  (p32_ready[p-num_8b_ports])
            );
        end
    end

    assign overflow_8b  = overflow_all[num_8b_ports-1:0];
    assign overflow_32b = overflow_all[num_ports-1:num_8b_ports];

endmodule

// ==== tb/mpls_egress_tb_cases.svh ====
// MPLS egress stimulus table

`ifndef MPLS_EGRESS_TB_CASES_SVH
`define MPLS_EGRESS_TB_CASES_SVH

localparam logic [1:0] stall_free   = 2'd0;
localparam logic [1:0] stall_random = 2'd1;
localparam logic [1:0] stall_held   = 2'd2;

typedef struct packed {
    logic        do_reset;
    logic [2:0]  port;
    logic [15:0] len;
    logic [1:0]  stall;
    logic [5:0]  exp_ovf;
} case_t;

localparam int num_cases = 13;

// Columns are reset before the row, port, byte length, ready mode on that port
// and overflow bits after the row with bit n for port n
case_t cases [num_cases] = '{
    '{1'b0, 3'd0, 16'd13,  stall_free,   6'b000000},
    '{1'b0, 3'd1, 16'd8,   stall_free,   6'b000000},
    '{1'b0, 3'd2, 16'd1,   stall_free,   6'b000000},
    '{1'b0, 3'd3, 16'd13,  stall_free,   6'b000000},
    '{1'b0, 3'd4, 16'd12,  stall_free,   6'b000000},
    '{1'b0, 3'd5, 16'd30,  stall_free,   6'b000000},
    '{1'b0, 3'd1, 16'd100, stall_random, 6'b000000},
    '{1'b0, 3'd4, 16'd128, stall_random, 6'b000000},
    '{1'b0, 3'd2, 16'd160, stall_held,   6'b000100},
    '{1'b0, 3'd3, 16'd21,  stall_free,   6'b000100},
    '{1'b0, 3'd5, 16'd160, stall_held,   6'b100100},
    '{1'b0, 3'd0, 16'd40,  stall_random, 6'b100100},
    '{1'b1, 3'd5, 16'd7,   stall_free,   6'b000000}
};

`endif

// ==== tb/mpls_egress_tb.sv ====
// MPLS egress testbench

module mpls_egress_tb;

    localparam int n8         = 3;
    localparam int n32        = 3;
    localparam int num_ports  = n8 + n32;
    localparam int fifo_depth = 16;

    `include "mpls_egress_tb_cases.svh"

    logic                           clk_ifc = 1'b0;
    logic                           rst_n;
    logic                           egr_valid;
    mpls_egress_pkg::egr_word_u     egr_data;
    mpls_egress_pkg::egr_keep_t     egr_keep;
    logic                           egr_last;
    mpls_egress_pkg::egr_port_idx_t egr_port;
    logic [n8-1:0]                  p8_valid;
    logic [n8-1:0][7:0]             p8_data;
    logic [n8-1:0]                  p8_last;
    logic [n32-1:0]                 p32_valid;
    logic [n32-1:0][31:0]           p32_data;
    logic [n32-1:0][3:0]            p32_keep;
    logic [n32-1:0]                 p32_last;
    logic [n8-1:0]                  overflow_8b;
    logic [n32-1:0]                 overflow_32b;
    logic [num_ports-1:0]           ready_all = '1;
    logic [1:0]                     stall_mode [num_ports] = '{default: 2'd0};
    integer                         seed = 11;
    logic [31:0]                    rnd;
    int                             cycles = 0;
    int                             cycle_limit = 0;

    // Beats seen per port with bytes kept in arrival order
    logic [7:0]                     got_bytes [num_ports][$];
    int                             beat_count [num_ports];
    int                             last_count [num_ports];
    int                             last_at [num_ports];
    logic [3:0]                     last_keep [num_ports];

    mpls_egress #(
        .num_8b_ports  (n8),
        .num_32b_ports (n32),
        .fifo_depth    (fifo_depth)
    ) dut_i (
        .clk_ifc      (clk_ifc),
        .rst_n        (rst_n),
        .egr_valid    (egr_valid),
        .egr_data     (egr_data),
        .egr_keep     (egr_keep),
        .egr_last     (egr_last),
        .egr_port     (egr_port),
        .p8_valid     (p8_valid),
        .p8_data      (p8_data),
        .p8_last      (p8_last),
        .p8_ready     (ready_all[n8-1:0]),
        .p32_valid    (p32_valid),
        .p32_data     (p32_data),
        .p32_keep     (p32_keep),
        .p32_last     (p32_last),
        .p32_ready    (ready_all[num_ports-1:n8]),
        .overflow_8b  (overflow_8b),
        .overflow_32b (overflow_32b)
    );

    always #50 clk_ifc = ~clk_ifc;

    //////////////////////////////
    // Ready drive and collectors
    //////////////////////////////

    always @(negedge clk_ifc) begin
        for (int p = 0; p < num_ports; p++) begin
            if (stall_mode[p] == stall_random) begin
                rnd = $random(seed);
                ready_all[p] = rnd[0];
            end else begin
                ready_all[p] = (stall_mode[p] != stall_held);
            end
        end
    end

    always @(posedge clk_ifc) begin
        if (rst_n) begin
            for (int p = 0; p < n8; p++) begin
                if (p8_valid[p] && ready_all[p]) begin
                    got_bytes[p].push_back(p8_data[p]);
                    beat_count[p]++;
                    if (p8_last[p]) begin
                        last_count[p]++;
                        last_at[p] = got_bytes[p].size();
                    end
                end
            end
            for (int q = 0; q < n32; q++) begin
                if (p32_valid[q] && ready_all[n8+q]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (p32_keep[q][b]) begin
                            got_bytes[n8+q].push_back(p32_data[q][8*b +: 8]);
                        end
                    end
                    beat_count[n8+q]++;
                    if (p32_last[q]) begin
                        last_count[n8+q]++;
                        last_at[n8+q] = got_bytes[n8+q].size();
                        last_keep[n8+q] = p32_keep[q];
                    end
                end
            end
        end
    end

    always @(posedge clk_ifc) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "Run stopped on timeout");
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    function automatic logic [7:0] pkt_byte(input int r, input int i);
        return 8'((r * 16 + i) % 256);
    endfunction

    function automatic logic port_valid(input int p);
        if (p < n8) begin
            return p8_valid[p];
        end
        return p32_valid[p-n8];
    endfunction

    task automatic clear_results();
        for (int p = 0; p < num_ports; p++) begin
            got_bytes[p].delete();
            beat_count[p] = 0;
            last_count[p] = 0;
            last_at[p]    = 0;
            last_keep[p]  = '0;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(negedge clk_ifc);
        rst_n = 1'b1;
        clear_results();
    endtask

    // Mode changes land between edges so the ready driver sees them cleanly
    task automatic set_stall(input int p, input logic [1:0] mode);
        @(posedge clk_ifc);
        stall_mode[p] = mode;
        @(negedge clk_ifc);
    endtask

    task automatic send_packet(input int r, input int port, input int len);
        int nwords;
        nwords = (len + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            @(negedge clk_ifc);
            egr_valid = 1'b1;
            egr_port  = 3'(port);
            egr_last  = (w == nwords - 1);
            egr_data  = '0;
            egr_keep  = '0;
            for (int i = 0; i < 8; i++) begin
                if (w * 8 + i < len) begin
                    egr_data.as_bytes[i] = pkt_byte(r, w * 8 + i);
                    egr_keep[i] = 1'b1;
                end
            end
        end
        @(negedge clk_ifc);
        egr_valid = 1'b0;
        egr_last  = 1'b0;
    endtask

    task automatic check_packet(input int r, input int port, input int len);
        string sig;
        logic [3:0] exp_keep;
        sig = (port < n8) ? $sformatf("p8_data[%0d]", port)
                          : $sformatf("p32_data[%0d]", port - n8);
        check_value({sig, " byte count"}, got_bytes[port].size(), len);
        for (int i = 0; i < len; i++) begin
            check_value($sformatf("%s byte %0d", sig, i), got_bytes[port][i], pkt_byte(r, i));
        end
        check_value({sig, " last count"}, last_count[port], 1);
        check_value({sig, " last position"}, last_at[port], len);
        if (port < n8) begin
            check_value({sig, " beat count"}, beat_count[port], len);
        end else begin
            // Final beat keeps only the bytes left over from the low bits up
            exp_keep = (len % 4 == 0) ? 4'hf : 4'((1 << (len % 4)) - 1);
            check_value({sig, " beat count"}, beat_count[port], (len + 3) / 4);
            check_value($sformatf("p32_keep[%0d] last", port - n8), last_keep[port], exp_keep);
        end
    endtask

    task automatic run_row(input int r);
        int port;
        int len;
        int idle;
        port = int'(cases[r].port);
        len  = int'(cases[r].len);
        if (cases[r].do_reset) begin
            apply_reset();
        end
        set_stall(port, cases[r].stall);
        send_packet(r, port, len);
        if (cases[r].stall == stall_held) begin
            repeat ((len + 7) / 8 + 20) @(negedge clk_ifc);
            // First lane of the packet waits on the stalled port
            check_value("held port valid", port_valid(port), 1'b1);
            if (port < n8) begin
                check_value($sformatf("p8_data[%0d] held", port), p8_data[port],
                            pkt_byte(r, 0));
            end else begin
                check_value($sformatf("p32_data[%0d] held", port - n8), p32_data[port - n8],
                            {pkt_byte(r, 3), pkt_byte(r, 2), pkt_byte(r, 1), pkt_byte(r, 0)});
            end
            set_stall(port, stall_free);
            // Let the stuck words drain so later rows start clean
            idle = 0;
            while (idle < 8) begin
                @(negedge clk_ifc);
                idle = port_valid(port) ? 0 : idle + 1;
            end
        end else begin
            while (last_count[port] == 0) begin
                @(negedge clk_ifc);
            end
            repeat (4) @(negedge clk_ifc);
            check_packet(r, port, len);
            set_stall(port, stall_free);
        end
        for (int p = 0; p < num_ports; p++) begin
            if (p != port) begin
                check_value($sformatf("port %0d beat count", p), beat_count[p], 0);
            end
        end
        check_value("overflow", {overflow_32b, overflow_8b}, cases[r].exp_ovf);
        clear_results();
    endtask

    initial begin
        rst_n     = 1'b0;
        egr_valid = 1'b0;
        egr_data  = '0;
        egr_keep  = '0;
        egr_last  = 1'b0;
        egr_port  = '0;
        cycle_limit = 200;
        for (int r = 0; r < num_cases; r++) begin
            cycle_limit += int'(cases[r].len) * 4;
        end
        apply_reset();
        for (int r = 0; r < num_cases; r++) begin
            run_row(r);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== mpls_egress.f ====
+incdir+tb
hw/mpls_egress_pkg.sv
hw/egress_port_fifo.sv
hw/egress_width_serializer.sv
hw/mpls_egress.sv
tb/mpls_egress_tb.sv
